// File: logic/wfq_cfg_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Field widths of the rank calculator
////////////////////////////////////////////////////////////////////////

package wfq_cfg_pkg;

    // Packet descriptor
    localparam int PKT_SIZE_W = 11;
    localparam int CLASS_W    = 5;
    localparam int PORT_SEL_W = 8;

    // Per-flow state
    localparam int WEIGHT_W   = 17;
    localparam int ROUND_W    = 17;
    localparam int EPOCH_W    = 2;
    localparam int VTIME_W    = EPOCH_W + ROUND_W;

    // Wide enough for 5 ports of 32 classes
    localparam int FLOW_ID_W  = 8;

    ////////////////////////////////////////////////////////////////////
    // Pipeline timing
    ////////////////////////////////////////////////////////////////////

    // One quotient bit per divider stage
    localparam int DIV_LATENCY  = PKT_SIZE_W;

    // Input register, divider, writeback register
    localparam int RANK_LATENCY = DIV_LATENCY + 2;

endpackage

`default_nettype wire

// File: logic/wfq_types_pkg.sv
`default_nettype none

package wfq_types_pkg;

    import wfq_cfg_pkg::*;

    // Virtual time, read as one word for the add
    // or as epoch and round for the floor compare
    typedef union packed {
        logic [VTIME_W-1:0] word;
        struct packed {
            logic [EPOCH_W-1:0] epoch;
            logic [ROUND_W-1:0] round;
        } f;
    } vtime_u;

    // CPU access target
    typedef enum logic {
        SEL_WEIGHT = 1'b0,
        SEL_VTIME  = 1'b1
    } cpu_sel_e;

endpackage

`default_nettype wire

// File: logic/wfq_divider.sv
`timescale 1ns/100ps
`default_nettype none

module wfq_divider
    import wfq_cfg_pkg::*;
(
    input  wire                  clk_cp,
    input  wire                  rst,
    input  wire                  start_i,
    input  wire [PKT_SIZE_W-1:0] size_i,
    input  wire [WEIGHT_W-1:0]   weight_i,
    input  wire [FLOW_ID_W-1:0]  flow_i,
    output logic                 valid_o,
    output logic [PKT_SIZE_W-1:0] quot_o,
    output logic [FLOW_ID_W-1:0] flow_o
);

    logic [DIV_LATENCY-1:0] vld_q;
    logic [PKT_SIZE_W-1:0]  rem_q  [DIV_LATENCY];
    // Dividend bits shift out at the top, quotient bits in at the bottom
    logic [PKT_SIZE_W-1:0]  num_q  [DIV_LATENCY];
    logic [WEIGHT_W-1:0]    den_q  [DIV_LATENCY];
    logic [FLOW_ID_W-1:0]   flow_q [DIV_LATENCY];

    // One restoring step, returns {remainder, shifted dividend/quotient}
    function automatic logic [2*PKT_SIZE_W-1:0] div_step(
        input logic [PKT_SIZE_W-1:0] rem,
        input logic [PKT_SIZE_W-1:0] num,
        input logic [WEIGHT_W-1:0]   den
    );
        logic [WEIGHT_W-1:0] trial;
        logic                fits;
        trial = WEIGHT_W'({rem, num[PKT_SIZE_W-1]});
        fits  = trial >= den;
        if (fits)
            trial = trial - den;
        // Partial remainder never exceeds the partial dividend
        return {trial[PKT_SIZE_W-1:0], num[PKT_SIZE_W-2:0], fits};
    endfunction

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
            vld_q <= '0;
        else
            vld_q <= {vld_q[DIV_LATENCY-2:0], start_i};
    end

    always_ff @(posedge clk_cp)
    begin
        {rem_q[0], num_q[0]} <= div_step(PKT_SIZE_W'(0), size_i, weight_i);
        den_q[0]  <= weight_i;
        flow_q[0] <= flow_i;
        for (int s = 1; s < DIV_LATENCY; s++)
        begin
            {rem_q[s], num_q[s]} <= div_step(rem_q[s-1], num_q[s-1], den_q[s-1]);
            den_q[s]  <= den_q[s-1];
            flow_q[s] <= flow_q[s-1];
        end
    end

    assign valid_o = vld_q[DIV_LATENCY-1];
    assign quot_o  = num_q[DIV_LATENCY-1];
    assign flow_o  = flow_q[DIV_LATENCY-1];

endmodule

`default_nettype wire

// File: logic/wfq_flow_table.sv
`timescale 1ns/100ps
`default_nettype none

module wfq_flow_table
    import wfq_cfg_pkg::*;
    import wfq_types_pkg::*;
#(
    parameter int NUM_PORTS   = 5,
    parameter int NUM_CLASSES = 32
)
(
    input  wire                 clk_cp,
    input  wire                 rst,
    input  wire [FLOW_ID_W-1:0] rd_flow_i,
    input  wire                 wb_en_i,
    input  wire [FLOW_ID_W-1:0] wb_flow_i,
    input  wire [VTIME_W-1:0]   wb_vtime_i,
    input  wire                 cpu_gnt_i,
    input  wire                 cpu_write_i,
    input  wire cpu_sel_e       cpu_sel_i,
    input  wire [FLOW_ID_W-1:0] cpu_addr_i,
    input  wire [WEIGHT_W-1:0]  cpu_wdata_i,
    output logic [WEIGHT_W-1:0] weight_o,
    output logic [VTIME_W-1:0]  vtime_o,
    output logic [VTIME_W-1:0]  cpu_rdata_o
);

    localparam int NUM_FLOWS = NUM_PORTS * NUM_CLASSES;

    logic [WEIGHT_W-1:0] weight_q [NUM_FLOWS];
    logic [VTIME_W-1:0]  vtime_q  [NUM_FLOWS];
    logic                cpu_wr_weight;

    // Only weights are writable from the CPU
    assign cpu_wr_weight = cpu_gnt_i && cpu_write_i && (cpu_sel_i == SEL_WEIGHT);

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            for (int i = 0; i < NUM_FLOWS; i++)
            begin
                weight_q[i] <= WEIGHT_W'(1);
                vtime_q[i]  <= '0;
            end
        end
        else
        begin
            if (wb_en_i)
                vtime_q[wb_flow_i] <= wb_vtime_i;
            if (cpu_wr_weight)
                weight_q[cpu_addr_i] <= cpu_wdata_i;
        end
    end

    // CPU read data, a write echoes the stored weight
    always_ff @(posedge clk_cp)
    begin
        if (cpu_wr_weight)
            cpu_rdata_o <= VTIME_W'(cpu_wdata_i);
        else if (cpu_gnt_i && cpu_sel_i == SEL_WEIGHT)
            cpu_rdata_o <= VTIME_W'(weight_q[cpu_addr_i]);
        else if (cpu_gnt_i)
            cpu_rdata_o <= vtime_q[cpu_addr_i];
    end

    // Pipeline side, combinational
    assign weight_o = weight_q[rd_flow_i];
    assign vtime_o  = vtime_q[wb_flow_i];

    // Writeback owns the time array in its cycle
    a_no_gnt_in_wb: assert property (@(posedge clk_cp) disable iff (!rst)
        !(cpu_gnt_i && wb_en_i))
        else $error("CPU grant collides with rank writeback");

endmodule

`default_nettype wire

// File: logic/wfq_table_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wfq_table_arbiter
(
    input  wire  clk_cp,
    input  wire  rst,
    input  wire  pipe_rd_busy_i,
    input  wire  pipe_wb_busy_i,
    input  wire  cpu_pending_i,
    output logic cpu_gnt_o
);

    localparam int WAIT_W       = 7;
    localparam int STARVE_LIMIT = 64;

    logic [WAIT_W-1:0] wait_q;

    // Pipeline always wins, CPU fills idle cycles
    assign cpu_gnt_o = cpu_pending_i && !pipe_rd_busy_i && !pipe_wb_busy_i;

    // Cycles a pending request has gone without grant, saturating
    always_ff @(posedge clk_cp)
    begin
        if (!rst)
            wait_q <= '0;
        else if (!cpu_pending_i || cpu_gnt_o)
            wait_q <= '0;
        else if (wait_q != '1)
            wait_q <= wait_q + WAIT_W'(1);
    end

    a_no_starve: assert property (@(posedge clk_cp) disable iff (!rst)
        wait_q <= WAIT_W'(STARVE_LIMIT))
        else $error("CPU request starved for more than %0d cycles", STARVE_LIMIT);

endmodule

`default_nettype wire

// File: logic/wfq_cpu_port.sv
`timescale 1ns/100ps
`default_nettype none

module wfq_cpu_port
    import wfq_cfg_pkg::*;
    import wfq_types_pkg::*;
#(
    parameter int NUM_PORTS   = 5,
    parameter int NUM_CLASSES = 32
)
(
    input  wire                  clk_cp,
    input  wire                  rst,
    input  wire                  cpu_req_i,
    input  wire                  cpu_write_i,
    input  wire cpu_sel_e        cpu_sel_i,
    input  wire [FLOW_ID_W-1:0]  cpu_addr_i,
    input  wire [WEIGHT_W-1:0]   cpu_wdata_i,
    input  wire                  cpu_gnt_i,
    input  wire [VTIME_W-1:0]    tbl_rdata_i,
    output logic                 cpu_pending_o,
    output logic                 tbl_write_o,
    output cpu_sel_e             tbl_sel_o,
    output logic [FLOW_ID_W-1:0] tbl_addr_o,
    output logic [WEIGHT_W-1:0]  tbl_wdata_o,
    output logic                 cpu_ack_o,
    output logic [VTIME_W-1:0]   cpu_rdata_o
);

    localparam int NUM_FLOWS = NUM_PORTS * NUM_CLASSES;

    logic take;

    // New request only once the previous one is fully acknowledged
    assign take = cpu_req_i && !cpu_pending_o && !cpu_ack_o;

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            cpu_pending_o <= 1'b0;
            cpu_ack_o     <= 1'b0;
        end
        else
        begin
            cpu_ack_o <= cpu_gnt_i;
            if (cpu_gnt_i)
                cpu_pending_o <= 1'b0;
            else if (take)
                cpu_pending_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_cp)
    begin
        if (take)
        begin
            tbl_write_o <= cpu_write_i;
            tbl_sel_o   <= cpu_sel_i;
            tbl_addr_o  <= cpu_addr_i;
            // Zero weight would stall the flow, store 1 instead
            tbl_wdata_o <= (cpu_wdata_i == '0) ? WEIGHT_W'(1) : cpu_wdata_i;
        end
    end

    // Table registers its read data in the grant cycle
    assign cpu_rdata_o = tbl_rdata_i;

    a_addr_range: assert property (@(posedge clk_cp) disable iff (!rst)
        cpu_pending_o |-> (tbl_addr_o < FLOW_ID_W'(NUM_FLOWS)))
        else $error("CPU address %0d beyond flow table", tbl_addr_o);

endmodule

`default_nettype wire

// File: logic/wfq_rank_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module wfq_rank_pipe
    import wfq_cfg_pkg::*;
    import wfq_types_pkg::*;
#(
    parameter int NUM_PORTS   = 5,
    parameter int NUM_CLASSES = 32
)
(
    input  wire                          clk_cp,
    input  wire                          rst,
    input  wire                          pkt_valid_i,
    input  wire [PORT_SEL_W-1:0]         pkt_port_i,
    input  wire [CLASS_W-1:0]            pkt_class_i,
    input  wire [PKT_SIZE_W-1:0]         pkt_size_i,
    input  wire                          deq_valid_i,
    input  wire [$clog2(NUM_PORTS)-1:0]  deq_port_i,
    input  wire [VTIME_W-1:0]            deq_vtime_i,
    input  wire                          div_valid_i,
    input  wire [PKT_SIZE_W-1:0]         div_quot_i,
    input  wire [FLOW_ID_W-1:0]          div_flow_i,
    input  wire [WEIGHT_W-1:0]           tbl_weight_i,
    input  wire [VTIME_W-1:0]            tbl_vtime_i,
    output logic                         div_start_o,
    output logic [PKT_SIZE_W-1:0]        div_size_o,
    output logic [WEIGHT_W-1:0]          div_weight_o,
    output logic [FLOW_ID_W-1:0]         div_flow_o,
    output logic [FLOW_ID_W-1:0]         tbl_rd_flow_o,
    output logic [FLOW_ID_W-1:0]         tbl_wb_flow_o,
    output logic                         tbl_wb_en_o,
    output logic [VTIME_W-1:0]           tbl_wb_vtime_o,
    output logic                         pipe_rd_busy_o,
    output logic                         pipe_wb_busy_o,
    output logic                         rank_valid_o,
    output logic [VTIME_W-1:0]           rank_o,
    output logic [FLOW_ID_W-1:0]         rank_flow_o
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    logic [PORT_W-1:0]     port_id;
    logic [FLOW_ID_W-1:0]  flow_id;
    logic                  s1_valid;
    logic [FLOW_ID_W-1:0]  s1_flow;
    logic [PKT_SIZE_W-1:0] s1_size;
    vtime_u                floor_q [NUM_PORTS];
    logic [PORT_W-1:0]     wb_port;
    vtime_u                flow_t;
    vtime_u                floor_t;
    vtime_u                start_t;
    vtime_u                next_t;
    logic                  floor_ahead;

    ////////////////////////////////////////////////////////////////////
    // Flow mapping
    ////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (pkt_port_i)
            8'h01:   port_id = PORT_W'(0);
            8'h04:   port_id = PORT_W'(1);
            8'h10:   port_id = PORT_W'(2);
            8'h40:   port_id = PORT_W'(3);
            // Anything else goes to the CPU port
            default: port_id = PORT_W'(NUM_PORTS - 1);
        endcase
        flow_id = FLOW_ID_W'(port_id) * FLOW_ID_W'(NUM_CLASSES) + FLOW_ID_W'(pkt_class_i);
    end

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= pkt_valid_i;
    end

    always_ff @(posedge clk_cp)
    begin
        s1_flow <= flow_id;
        s1_size <= pkt_size_i;
    end

    // Weight read straight into the divider
    assign tbl_rd_flow_o  = s1_flow;
    assign div_start_o    = s1_valid;
    assign div_size_o     = s1_size;
    assign div_weight_o   = tbl_weight_i;
    assign div_flow_o     = s1_flow;
    assign pipe_rd_busy_o = pkt_valid_i;

    // Dequeue floors, visible from the next cycle on
    always_ff @(posedge clk_cp)
    begin
        if (!rst)
        begin
            for (int p = 0; p < NUM_PORTS; p++)
                floor_q[p] <= '0;
        end
        else if (deq_valid_i && deq_port_i < PORT_W'(NUM_PORTS))
        begin
            floor_q[deq_port_i] <= deq_vtime_i;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////////////

    always_comb
    begin
        wb_port      = PORT_W'(div_flow_i / FLOW_ID_W'(NUM_CLASSES));
        flow_t.word  = tbl_vtime_i;
        floor_t      = floor_q[wb_port];
        // Floor one epoch ahead, or same epoch with a later round
        floor_ahead  = (floor_t.f.epoch == flow_t.f.epoch + EPOCH_W'(1)) ||
                       (floor_t.f.epoch == flow_t.f.epoch &&
                        floor_t.f.round > flow_t.f.round);
        start_t      = floor_ahead ? floor_t : flow_t;
        // Round carry spills into the epoch
        next_t.word  = start_t.word + VTIME_W'(div_quot_i);
    end

    assign tbl_wb_en_o    = div_valid_i;
    assign tbl_wb_flow_o  = div_flow_i;
    assign tbl_wb_vtime_o = next_t.word;
    assign pipe_wb_busy_o = div_valid_i;

    always_ff @(posedge clk_cp)
    begin
        if (!rst)
            rank_valid_o <= 1'b0;
        else
            rank_valid_o <= div_valid_i;
    end

    always_ff @(posedge clk_cp)
    begin
        rank_o      <= next_t.word;
        rank_flow_o <= div_flow_i;
    end

    a_div_has_start: assert property (@(posedge clk_cp) disable iff (!rst)
        div_valid_i |-> $past(div_start_o, DIV_LATENCY))
        else $error("Divider result without a matching start");

endmodule

`default_nettype wire

// File: logic/wfq_top.sv
`timescale 1ns/100ps
`default_nettype none

module wfq_top
    import wfq_cfg_pkg::*;
    import wfq_types_pkg::*;
#(
    parameter int NUM_PORTS   = 5,
    parameter int NUM_CLASSES = 32
)
(
    input  wire                          clk_cp,
    input  wire                          rst,
    input  wire                          pkt_valid_i,
    input  wire [PORT_SEL_W-1:0]         pkt_port_i,
    input  wire [CLASS_W-1:0]            pkt_class_i,
    input  wire [PKT_SIZE_W-1:0]         pkt_size_i,
    input  wire                          deq_valid_i,
    input  wire [$clog2(NUM_PORTS)-1:0]  deq_port_i,
    input  wire [VTIME_W-1:0]            deq_vtime_i,
    input  wire                          cpu_req_i,
    input  wire                          cpu_write_i,
    input  wire cpu_sel_e                cpu_sel_i,
    input  wire [FLOW_ID_W-1:0]          cpu_addr_i,
    input  wire [WEIGHT_W-1:0]           cpu_wdata_i,
    output logic                         rank_valid_o,
    output logic [VTIME_W-1:0]           rank_o,
    output logic [FLOW_ID_W-1:0]         rank_flow_o,
    output logic                         cpu_ack_o,
    output logic [VTIME_W-1:0]           cpu_rdata_o
);

    // Pipe to divider
    logic                  div_start;
    logic [PKT_SIZE_W-1:0] div_size;
    logic [WEIGHT_W-1:0]   div_weight;
    logic [FLOW_ID_W-1:0]  div_flow_in;
    logic                  div_valid;
    logic [PKT_SIZE_W-1:0] div_quot;
    logic [FLOW_ID_W-1:0]  div_flow_out;

    // Pipe to table
    logic [FLOW_ID_W-1:0]  tbl_rd_flow;
    logic [WEIGHT_W-1:0]   tbl_weight;
    logic [VTIME_W-1:0]    tbl_vtime;
    logic                  tbl_wb_en;
    logic [FLOW_ID_W-1:0]  tbl_wb_flow;
    logic [VTIME_W-1:0]    tbl_wb_vtime;
    logic                  pipe_rd_busy;
    logic                  pipe_wb_busy;

    // CPU side of the table
    logic                  cpu_pending;
    logic                  cpu_gnt;
    logic                  tbl_write;
    cpu_sel_e              tbl_sel;
    logic [FLOW_ID_W-1:0]  tbl_addr;
    logic [WEIGHT_W-1:0]   tbl_wdata;
    logic [VTIME_W-1:0]    tbl_rdata;

    wfq_rank_pipe #(.NUM_PORTS(NUM_PORTS), .NUM_CLASSES(NUM_CLASSES)) i_rank_pipe (
        .clk_cp, .rst,
        .pkt_valid_i, .pkt_port_i, .pkt_class_i, .pkt_size_i,
        .deq_valid_i, .deq_port_i, .deq_vtime_i,
        .div_valid_i    (div_valid),
        .div_quot_i     (div_quot),
        .div_flow_i     (div_flow_out),
        .tbl_weight_i   (tbl_weight),
        .tbl_vtime_i    (tbl_vtime),
        .div_start_o    (div_start),
        .div_size_o     (div_size),
        .div_weight_o   (div_weight),
        .div_flow_o     (div_flow_in),
        .tbl_rd_flow_o  (tbl_rd_flow),
        .tbl_wb_flow_o  (tbl_wb_flow),
        .tbl_wb_en_o    (tbl_wb_en),
        .tbl_wb_vtime_o (tbl_wb_vtime),
        .pipe_rd_busy_o (pipe_rd_busy),
        .pipe_wb_busy_o (pipe_wb_busy),
        .rank_valid_o, .rank_o, .rank_flow_o
    );

    wfq_divider i_divider (
        .clk_cp, .rst,
        .start_i  (div_start),
        .size_i   (div_size),
        .weight_i (div_weight),
        .flow_i   (div_flow_in),
        .valid_o  (div_valid),
        .quot_o   (div_quot),
        .flow_o   (div_flow_out)
    );

    wfq_flow_table #(.NUM_PORTS(NUM_PORTS), .NUM_CLASSES(NUM_CLASSES)) i_flow_table (
        .clk_cp, .rst,
        .rd_flow_i   (tbl_rd_flow),
        .wb_en_i     (tbl_wb_en),
        .wb_flow_i   (tbl_wb_flow),
        .wb_vtime_i  (tbl_wb_vtime),
        .cpu_gnt_i   (cpu_gnt),
        .cpu_write_i (tbl_write),
        .cpu_sel_i   (tbl_sel),
        .cpu_addr_i  (tbl_addr),
        .cpu_wdata_i (tbl_wdata),
        .weight_o    (tbl_weight),
        .vtime_o     (tbl_vtime),
        .cpu_rdata_o (tbl_rdata)
    );

    wfq_table_arbiter i_table_arbiter (
        .clk_cp, .rst,
        .pipe_rd_busy_i (pipe_rd_busy),
        .pipe_wb_busy_i (pipe_wb_busy),
        .cpu_pending_i  (cpu_pending),
        .cpu_gnt_o      (cpu_gnt)
    );

    wfq_cpu_port #(.NUM_PORTS(NUM_PORTS), .NUM_CLASSES(NUM_CLASSES)) i_cpu_port (
        .clk_cp, .rst,
        .cpu_req_i, .cpu_write_i, .cpu_sel_i, .cpu_addr_i, .cpu_wdata_i,
        .cpu_gnt_i     (cpu_gnt),
        .tbl_rdata_i   (tbl_rdata),
        .cpu_pending_o (cpu_pending),
        .tbl_write_o   (tbl_write),
        .tbl_sel_o     (tbl_sel),
        .tbl_addr_o    (tbl_addr),
        .tbl_wdata_o   (tbl_wdata),
        .cpu_ack_o, .cpu_rdata_o
    );

endmodule

`default_nettype wire

// File: test/wfq_tb_model.svh
`ifndef WFQ_TB_MODEL_SVH
`define WFQ_TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////
// Reference model state
////////////////////////////////////////////////////////////////////////

logic [WEIGHT_W-1:0] m_weight [160];
logic [VTIME_W-1:0]  m_vtime  [160];
logic [VTIME_W-1:0]  m_floor  [5];
logic [19:0]         lfsr_q;

function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    logic        b;
    r = 0;
    // Taps 20 and 17, one step per bit taken
    for (int i = 0; i < n; i++)
    begin
        b      = lfsr_q[19] ^ lfsr_q[16];
        lfsr_q = {lfsr_q[18:0], b};
        r      = (r << 1) | b;
    end
    return r;
endfunction

function automatic int port_of(input logic [7:0] sel);
    case (sel)
        8'h01:   return 0;
        8'h04:   return 1;
        8'h10:   return 2;
        8'h40:   return 3;
        default: return 4;
    endcase
endfunction

// Floor wins one epoch ahead, or same epoch with a later round
function automatic bit floor_wins(input logic [VTIME_W-1:0] fl, input logic [VTIME_W-1:0] t);
    logic [1:0] fe;
    logic [1:0] te;
    fe = fl[18:17];
    te = t[18:17];
    if (fe == te + 2'd1)
        return 1;
    return (fe == te) && (fl[16:0] > t[16:0]);
endfunction

function automatic logic [VTIME_W-1:0] model_rank(input int flow, input int size);
    logic [VTIME_W-1:0] start;
    logic [VTIME_W-1:0] fl;
    int                 quot;
    fl    = m_floor[flow / 32];
    start = floor_wins(fl, m_vtime[flow]) ? fl : m_vtime[flow];
    quot  = size / int'(m_weight[flow]);
    m_vtime[flow] = start + VTIME_W'(quot);
    return m_vtime[flow];
endfunction

task automatic model_reset();
    for (int i = 0; i < 160; i++)
    begin
        m_weight[i] = 1;
        m_vtime[i]  = 0;
    end
    for (int p = 0; p < 5; p++)
        m_floor[p] = 0;
    lfsr_q = 20'd99541;
endtask

`endif

// File: test/wfq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module wfq_tb
    import wfq_cfg_pkg::*;
    import wfq_types_pkg::*;
;

    typedef enum int {OP_WRITE, OP_READ, OP_PKT, OP_DEQ, OP_IDLE} op_e;

    typedef struct {
        op_e                 op;
        string               name;
        cpu_sel_e            sel;
        logic [7:0]          addr;
        logic [WEIGHT_W-1:0] wdata;
        logic [7:0]          port;
        logic [4:0]          cls;
        logic [10:0]         size;
        logic [2:0]          deq_port;
        logic [VTIME_W-1:0]  vtime;
        bit                  has_exp;
        logic [VTIME_W-1:0]  exp;
    } entry_t;

    logic                 clk_cp;
    logic                 rst;
    logic                 pkt_valid_i;
    logic [7:0]           pkt_port_i;
    logic [4:0]           pkt_class_i;
    logic [10:0]          pkt_size_i;
    logic                 deq_valid_i;
    logic [2:0]           deq_port_i;
    logic [VTIME_W-1:0]   deq_vtime_i;
    logic                 cpu_req_i;
    logic                 cpu_write_i;
    cpu_sel_e             cpu_sel_i;
    logic [7:0]           cpu_addr_i;
    logic [WEIGHT_W-1:0]  cpu_wdata_i;
    logic                 rank_valid_o;
    logic [VTIME_W-1:0]   rank_o;
    logic [7:0]           rank_flow_o;
    logic                 cpu_ack_o;
    logic [VTIME_W-1:0]   cpu_rdata_o;

    entry_t             tbl[$];
    logic [VTIME_W-1:0] q_rank[$];
    int                 q_flow[$];
    int                 q_cyc[$];
    string              q_name[$];
    int                 cyc;
    int                 limit;

    `include "wfq_tb_model.svh"

    wfq_top #(.NUM_PORTS(5), .NUM_CLASSES(32)) i_wfq_top (.*);

    always #2 clk_cp = ~clk_cp;

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act)
        else
        begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Table building
    ////////////////////////////////////////////////////////////////////

    task automatic add_entry(input op_e op, input string name, input cpu_sel_e sel,
                             input int addr, input int data, input bit has_exp,
                             input int exp);
        entry_t e;
        e          = '{op: op, name: name, sel: sel, default: '0};
        e.addr     = 8'(addr);
        e.wdata    = WEIGHT_W'(data);
        e.deq_port = 3'(addr);
        e.vtime    = VTIME_W'(data);
        e.has_exp  = has_exp;
        e.exp      = VTIME_W'(exp);
        tbl.push_back(e);
    endtask

    task automatic add_pkt(input string name, input int port, input int cls,
                           input int size, input bit has_exp, input int exp);
        entry_t e;
        e         = '{op: OP_PKT, name: name, sel: SEL_WEIGHT, default: '0};
        e.port    = 8'(port);
        e.cls     = 5'(cls);
        e.size    = 11'(size);
        e.has_exp = has_exp;
        e.exp     = VTIME_W'(exp);
        tbl.push_back(e);
    endtask

    // Random flows, kept off classes 3 and 10 used by directed tests
    task automatic add_random(input string name, input int n);
        int r;
        int c;
        int s;
        for (int i = 0; i < n; i++)
        begin
            r = rand_bits(3);
            c = rand_bits(5);
            s = rand_bits(11);
            if (c == 3 || c == 10)
                c = c ^ 1;
            case (r)
                0:       add_pkt(name, 8'h01, c, s, 0, 0);
                1:       add_pkt(name, 8'h04, c, s, 0, 0);
                2:       add_pkt(name, 8'h10, c, s, 0, 0);
                3:       add_pkt(name, 8'h40, c, s, 0, 0);
                default: add_pkt(name, 8'h80 | r, c, s, 0, 0);
            endcase
        end
    endtask

    task automatic fill_table();
        // After reset
        add_entry(OP_READ, "reset_w0", SEL_WEIGHT, 0, 0, 1, 1);
        add_entry(OP_READ, "reset_w37", SEL_WEIGHT, 37, 0, 1, 1);
        add_entry(OP_READ, "reset_w159", SEL_WEIGHT, 159, 0, 1, 1);
        add_entry(OP_READ, "reset_t0", SEL_VTIME, 0, 0, 1, 0);
        add_entry(OP_READ, "reset_t37", SEL_VTIME, 37, 0, 1, 0);
        add_entry(OP_READ, "reset_t159", SEL_VTIME, 159, 0, 1, 0);
        // Weight write and readback
        add_entry(OP_WRITE, "wr_w67", SEL_WEIGHT, 67, 7, 1, 7);
        add_entry(OP_READ, "rd_w67", SEL_WEIGHT, 67, 0, 1, 7);
        add_entry(OP_WRITE, "wr_w5_zero", SEL_WEIGHT, 5, 0, 1, 1);
        add_entry(OP_READ, "rd_w5_zero", SEL_WEIGHT, 5, 0, 1, 1);
        add_entry(OP_WRITE, "wr_w130", SEL_WEIGHT, 130, 3, 1, 3);
        // Single packets
        add_pkt("single_67", 8'h10, 3, 1500, 1, 214);
        add_pkt("cpu_port_130", 8'h23, 2, 100, 1, 33);
        add_entry(OP_IDLE, "idle", SEL_WEIGHT, 0, 0, 0, 0);
        // Back-to-back, mixed with random flows
        add_pkt("b2b_a", 8'h10, 3, 700, 1, 314);
        add_random("b2b_rand", 2);
        add_pkt("b2b_b", 8'h10, 3, 70, 1, 324);
        add_pkt("b2b_c", 8'h10, 3, 7, 1, 325);
        add_random("b2b_rand", 4);
        add_entry(OP_READ, "b2b_t67", SEL_VTIME, 67, 0, 1, 325);
        // Dequeue floors
        add_entry(OP_DEQ, "deq_ahead", SEL_WEIGHT, 2, 1000, 0, 0);
        add_pkt("floor_ahead", 8'h10, 3, 14, 1, 1002);
        add_entry(OP_DEQ, "deq_behind", SEL_WEIGHT, 2, 500, 0, 0);
        add_pkt("floor_behind", 8'h10, 3, 14, 1, 1004);
        add_random("burst", 10);
        add_entry(OP_READ, "burst_w67", SEL_WEIGHT, 67, 0, 1, 7);
        add_random("burst", 6);
        add_entry(OP_READ, "burst_t67", SEL_VTIME, 67, 0, 1, 1004);
        add_entry(OP_READ, "burst_t130", SEL_VTIME, 130, 0, 0, 0);
        // Epoch wrap on flow 10
        add_entry(OP_DEQ, "deq_epoch1", SEL_WEIGHT, 0, (1 << 17) + 131000, 0, 0);
        add_pkt("epoch_a", 8'h01, 10, 2047, 1, 264119);
        add_pkt("epoch_b", 8'h01, 10, 2047, 1, 266166);
        add_entry(OP_DEQ, "deq_epoch3", SEL_WEIGHT, 0, (3 << 17) + 131000, 0, 0);
        add_pkt("wrap_a", 8'h01, 10, 2047, 1, 1975);
        add_pkt("wrap_b", 8'h01, 10, 2047, 1, 4022);
        add_random("tail", 8);
        add_entry(OP_READ, "wrap_t10", SEL_VTIME, 10, 0, 1, 4022);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Rank checker and timeout
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk_cp)
    begin
        cyc = cyc + 1;
        if (cyc > limit)
        begin
            $display("Run timed out after %0d cycles", cyc);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    always @(negedge clk_cp)
    begin
        if (rst && rank_valid_o)
        begin
            assert (q_rank.size() != 0)
            else
            begin
                $display("Rank output appeared with no packet outstanding");
                $display(">>> FAIL");
                $fatal(1);
            end
            check_value({q_name[0], " latency"}, RANK_LATENCY, cyc - q_cyc[0]);
            check_value({q_name[0], " flow"}, q_flow[0], rank_flow_o);
            check_value({q_name[0], " rank"}, q_rank[0], rank_o);
            void'(q_rank.pop_front());
            void'(q_flow.pop_front());
            void'(q_cyc.pop_front());
            void'(q_name.pop_front());
        end
    end

    task automatic wait_drain();
        while (q_rank.size() != 0)
        begin
            @(posedge clk_cp);
            #0.5;
        end
    endtask

    task automatic cpu_access(input entry_t e);
        int exp;
        cpu_req_i   = 1'b1;
        cpu_write_i = (e.op == OP_WRITE);
        cpu_sel_i   = e.sel;
        cpu_addr_i  = e.addr;
        cpu_wdata_i = e.wdata;
        do
        begin
            @(posedge clk_cp);
            #0.5;
        end
        while (!cpu_ack_o);
        cpu_req_i = 1'b0;
        if (e.op == OP_WRITE)
            m_weight[e.addr] = (e.wdata == 0) ? WEIGHT_W'(1) : e.wdata;
        if (e.has_exp)
            exp = e.exp;
        else if (e.sel == SEL_VTIME)
            exp = m_vtime[e.addr];
        else
            exp = m_weight[e.addr];
        check_value(e.name, exp, cpu_rdata_o);
    endtask

    initial
    begin
        entry_t e;
        int     flow;
        logic [VTIME_W-1:0] r;
        clk_cp = 0;
        rst = 0;
        cyc = 0;
        limit = 1000;
        pkt_valid_i = 0;
        pkt_port_i = 0;
        pkt_class_i = 0;
        pkt_size_i = 0;
        deq_valid_i = 0;
        deq_port_i = 0;
        deq_vtime_i = 0;
        cpu_req_i = 0;
        cpu_write_i = 0;
        cpu_sel_i = SEL_WEIGHT;
        cpu_addr_i = 0;
        cpu_wdata_i = 0;
        model_reset();
        fill_table();
        limit = tbl.size() * 20 + 100;
        repeat (8) @(posedge clk_cp);
        #0.5;
        rst = 1;
        foreach (tbl[i])
        begin
            e = tbl[i];
            @(posedge clk_cp);
            #0.5;
            pkt_valid_i = 1'b0;
            deq_valid_i = 1'b0;
            // Time reads, writes and floors need an empty pipeline
            if (e.op == OP_WRITE || e.op == OP_DEQ || (e.op == OP_READ && e.sel == SEL_VTIME))
                wait_drain();
            case (e.op)
                OP_PKT:
                begin
                    flow = port_of(e.port) * 32 + e.cls;
                    r = model_rank(flow, e.size);
                    pkt_valid_i = 1'b1;
                    pkt_port_i = e.port;
                    pkt_class_i = e.cls;
                    pkt_size_i = e.size;
                    q_rank.push_back(e.has_exp ? e.exp : r);
                    q_flow.push_back(flow);
                    q_cyc.push_back(cyc);
                    q_name.push_back(e.name);
                end
                OP_DEQ:
                begin
                    deq_valid_i = 1'b1;
                    deq_port_i = e.deq_port;
                    deq_vtime_i = e.vtime;
                    m_floor[e.deq_port] = e.vtime;
                end
                OP_WRITE, OP_READ:
                    cpu_access(e);
                default:
                    ;
            endcase
        end
        @(posedge clk_cp);
        #0.5;
        pkt_valid_i = 1'b0;
        deq_valid_i = 1'b0;
        wait_drain();
        repeat (4) @(posedge clk_cp);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: wfq_calc.f
+incdir+test
logic/wfq_cfg_pkg.sv
logic/wfq_types_pkg.sv
logic/wfq_divider.sv
logic/wfq_flow_table.sv
logic/wfq_table_arbiter.sv
logic/wfq_cpu_port.sv
logic/wfq_rank_pipe.sv
logic/wfq_top.sv
test/wfq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rank calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wfq_calc.f --top-module wfq_tb -o wfq_sim \
    && ./obj_dir/wfq_sim > sim.log 2>&1

cat sim.log
grep -q ">>> PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
